// File: dcache_top.f
+incdir+include
hw/dcache_pkg.sv
hw/dcache_sram.sv
hw/dcache_data_array.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
test/dcache_tb.sv

// File: hw/dcache_ctrl.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  req,
  input  dcache_pkg::cpu_req_t                  held,
  input  logic                                  hit,
  input  dcache_pkg::way_t                      hit_way,
  input  dcache_pkg::way_t                      victim_way,
  input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0] entries,
  input  dcache_pkg::age_t [`DC_WAYS-1:0]       ages,
  input  logic                                  burst_done,
  input  logic [31:0]                           rdata_word,
  output logic                                  busy,
  output logic                                  ok,
  output logic [31:0]                           rdata,
  output logic                                  cpu_we,
  output dcache_pkg::way_t                      sel_way,
  output logic [`DC_WAYS-1:0]                   tag_we,
  output dcache_pkg::tag_entry_t                tag_wdata,
  output logic [`DC_WAYS-1:0]                   age_we,
  output dcache_pkg::age_t [`DC_WAYS-1:0]       age_wdata,
  output logic                                  wb_start,
  output logic                                  fill_start,
  output logic [31:0]                           wb_addr,
  output logic [31:0]                           fill_addr
);

  typedef enum logic [2:0] {
    st_idle,
    st_compare,
    st_wb,
    st_fill,
    st_retry
  } state_t;

  state_t                 state;
  state_t                 next_state;
  dcache_pkg::way_t       way_q;        // Way chosen for the miss
  dcache_pkg::way_t       access_way;
  dcache_pkg::tag_entry_t victim;
  dcache_pkg::age_t       old_age;
  logic                   access;
  logic                   miss;
  logic                   victim_dirty;

  assign busy         = (state != st_idle);
  assign access       = (state == st_compare && hit) || (state == st_retry);
  assign miss         = (state == st_compare) && !hit;
  assign access_way   = (state == st_retry) ? way_q : hit_way;
  assign victim       = entries[victim_way];
  assign victim_dirty = victim.valid && victim.dirty;

  assign sel_way = (state == st_compare) ? hit_way : way_q;
  assign cpu_we  = access && held.we;

  // Line addresses start at word 0
  assign wb_addr   = {victim.tag, held.addr.index, {(`DC_WORD_W + 2){1'b0}}};
  assign fill_addr = {held.addr.tag, held.addr.index, {(`DC_WORD_W + 2){1'b0}}};

  assign wb_start   = miss && victim_dirty;
  assign fill_start = (miss && !victim_dirty) || (state == st_wb && burst_done);

  //////////////////////////////////////////////////
  // Tag and LRU updates
  //////////////////////////////////////////////////
  always_comb
  begin
    tag_we = '0;
    if (access && held.we)
      tag_we[access_way] = 1'b1;  // Store marks dirty
    if (state == st_fill && burst_done)
      tag_we[way_q] = 1'b1;       // New line is clean
    tag_wdata.valid = 1'b1;
    tag_wdata.dirty = (state != st_fill);
    tag_wdata.tag   = held.addr.tag;
  end

  always_comb
  begin
    old_age = ages[access_way];
    for (int i = 0; i < `DC_WAYS; i++)
    begin
      if (dcache_pkg::way_t'(i) == access_way)
        age_wdata[i] = '0;
      else if (ages[i] <= old_age)
        age_wdata[i] = ages[i] + 1'b1;
      else
        age_wdata[i] = ages[i];
    end
    age_we = {`DC_WAYS{access}};
  end

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////
  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:    if (req) next_state = st_compare;
      st_compare: if (hit) next_state = st_idle;
                  else next_state = victim_dirty ? st_wb : st_fill;
      st_wb:      if (burst_done) next_state = st_fill;
      st_fill:    if (burst_done) next_state = st_retry;
      st_retry:   next_state = st_idle;
      default:    next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= st_idle;
      ok    <= 1'b0;
      way_q <= '0;
    end
    else
    begin
      state <= next_state;
      ok    <= access;
      if (miss)
        way_q <= victim_way;
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
      rdata <= held.we ? held.wdata : rdata_word;
  end

endmodule

// File: hw/dcache_data_array.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_data_array (
  input  logic                   clk,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic [`DC_WORD_W-1:0]  word,
  input  logic                   cpu_we,
  input  dcache_pkg::way_t       cpu_way,
  input  logic [3:0]             wbyte,
  input  logic [31:0]            wdata,
  input  logic                   fill_we,
  input  logic [`DC_WORD_W-1:0]  fill_word,
  input  logic [31:0]            fill_data,
  input  logic [`DC_WORD_W-1:0]  wb_word,
  output logic [31:0]            rdata,
  output logic [31:0]            wb_data
);

  localparam int sets = 2 ** `DC_INDEX_W;

  logic [31:0] mem [`DC_WAYS][sets][`DC_LINE_WORDS];

  always_ff @(posedge clk)
  begin
    if (cpu_we)
    begin
      for (int b = 0; b < 4; b++)
        if (wbyte[b])
          mem[cpu_way][index][word][8*b +: 8] <= wdata[8*b +: 8];
    end
    if (fill_we)
      mem[cpu_way][index][fill_word] <= fill_data;  // Whole word from refill
  end

  assign rdata   = mem[cpu_way][index][word];
  assign wb_data = mem[cpu_way][index][wb_word];

endmodule

// File: hw/dcache_lookup.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_lookup (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      req,
  input  dcache_pkg::cpu_req_t                      cpu_req,
  input  logic                                      busy,
  input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0]     entries,
  input  dcache_pkg::age_t [`DC_WAYS-1:0]           ages,
  output dcache_pkg::cpu_req_t                      held,
  output logic [`DC_INDEX_W-1:0]                    index,
  output logic                                      hit,
  output dcache_pkg::way_t                          hit_way,
  output dcache_pkg::way_t                          victim_way
);

  logic [`DC_WAYS-1:0] match;
  logic                any_invalid;
  dcache_pkg::way_t    first_invalid;
  dcache_pkg::way_t    oldest;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      held <= '0;
    else if (req && !busy)
      held <= cpu_req;
  end

  // New request indexes the arrays in the same cycle
  assign index = (req && !busy) ? cpu_req.addr.index : held.addr.index;

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////
  always_comb
  begin
    hit_way = '0;
    for (int i = `DC_WAYS - 1; i >= 0; i--)
    begin
      match[i] = entries[i].valid && (entries[i].tag == held.addr.tag);
      if (match[i])
        hit_way = dcache_pkg::way_t'(i);
    end
  end

  assign hit = |match;

  //////////////////////////////////////////////////
  // Victim selection
  //////////////////////////////////////////////////
  always_comb
  begin
    any_invalid   = 1'b0;
    first_invalid = '0;
    oldest        = '0;
    for (int i = `DC_WAYS - 1; i >= 0; i--)
    begin
      if (!entries[i].valid)
      begin
        any_invalid   = 1'b1;
        first_invalid = dcache_pkg::way_t'(i);
      end
    end
    for (int i = 1; i < `DC_WAYS; i++)
      if (ages[i] > ages[oldest])  // Strict, ties keep lower way
        oldest = dcache_pkg::way_t'(i);
  end

  assign victim_way = any_invalid ? first_invalid : oldest;

endmodule

// File: hw/dcache_mem_port.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_mem_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_start,
  input  logic                  fill_start,
  input  logic [31:0]           wb_addr,
  input  logic [31:0]           fill_addr,
  input  logic [31:0]           sdata,
  input  logic                  rdata_ok,
  input  logic                  wdata_ok,
  input  logic [31:0]           wb_data,
  output dcache_pkg::mem_rd_t   mem_rd,
  output dcache_pkg::mem_wr_t   mem_wr,
  output logic                  fill_we,
  output logic [`DC_WORD_W-1:0] fill_word,
  output logic [31:0]           fill_data,
  output logic [`DC_WORD_W-1:0] wb_word,
  output logic                  burst_done
);

  localparam logic [`DC_WORD_W-1:0] last_word = `DC_WORD_W'(`DC_LINE_WORDS - 1);

  logic                  rd_en;
  logic                  wr_en;
  logic [`DC_WORD_W-1:0] rd_cnt;
  logic [`DC_WORD_W-1:0] wr_cnt;
  logic [31:0]           raddr_q;
  logic [31:0]           waddr_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_en      <= 1'b0;
      wr_en      <= 1'b0;
      rd_cnt     <= '0;
      wr_cnt     <= '0;
      burst_done <= 1'b0;
    end
    else
    begin
      burst_done <= 1'b0;
      if (fill_start)
      begin
        rd_en  <= 1'b1;
        rd_cnt <= '0;
      end
      else if (rd_en && rdata_ok)
      begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == last_word)
        begin
          rd_en      <= 1'b0;
          burst_done <= 1'b1;
        end
      end
      if (wb_start)
      begin
        wr_en  <= 1'b1;
        wr_cnt <= '0;
      end
      else if (wr_en && wdata_ok)
      begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == last_word)
        begin
          wr_en      <= 1'b0;
          burst_done <= 1'b1;
        end
      end
    end
  end

  // Line addresses held for the whole burst
  always_ff @(posedge clk)
  begin
    if (fill_start)
      raddr_q <= fill_addr;
    if (wb_start)
      waddr_q <= wb_addr;
  end

  assign mem_rd = '{sen: rd_en, raddr: raddr_q};
  assign mem_wr = '{wen: wr_en, waddr: waddr_q, wdata: wb_data};

  assign fill_we   = rd_en && rdata_ok;
  assign fill_word = rd_cnt;
  assign fill_data = sdata;
  assign wb_word   = wr_cnt;  // Next word follows each accept

endmodule

// File: hw/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DC_TAG_W-1:0]   tag;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_WORD_W-1:0]  word;
    logic [1:0]             offset;  // Byte in word
  } dc_addr_t;

  typedef struct packed {
    dc_addr_t    addr;
    logic [31:0] wdata;
    logic [3:0]  wbyte;
    logic        we;
  } cpu_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`DC_TAG_W-1:0] tag;
  } tag_entry_t;

  typedef logic [1:0]           way_t;
  typedef logic [`DC_AGE_W-1:0] age_t;

  // Memory bus
  typedef struct packed {
    logic        sen;
    logic [31:0] raddr;
  } mem_rd_t;

  typedef struct packed {
    logic        wen;
    logic [31:0] waddr;
    logic [31:0] wdata;
  } mem_wr_t;

endpackage

// File: hw/dcache_sram.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_sram #(
  parameter type entry_t = logic
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic                   we,
  input  entry_t                 wdata,
  output entry_t                 rdata
);

  localparam int sets = 2 ** `DC_INDEX_W;

  entry_t mem [sets];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < sets; i++)
        mem[i] <= '0;
      rdata <= '0;
    end
    else
    begin
      if (we)
        mem[index] <= wdata;
      rdata <= mem[index];  // Registered read
    end
  end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic                 ok,
  output logic [31:0]          rdata,
  output dcache_pkg::mem_rd_t  mem_rd,
  output dcache_pkg::mem_wr_t  mem_wr,
  input  logic [31:0]          sdata,
  input  logic                 rdata_ok,
  input  logic                 wdata_ok
);

  dcache_pkg::cpu_req_t                  held;
  dcache_pkg::tag_entry_t [`DC_WAYS-1:0] entries;
  dcache_pkg::tag_entry_t                tag_wdata;
  dcache_pkg::age_t [`DC_WAYS-1:0]       ages;
  dcache_pkg::age_t [`DC_WAYS-1:0]       age_wdata;
  dcache_pkg::way_t                      hit_way;
  dcache_pkg::way_t                      victim_way;
  dcache_pkg::way_t                      sel_way;
  logic [`DC_WAYS-1:0]                   tag_we;
  logic [`DC_WAYS-1:0]                   age_we;
  logic [`DC_INDEX_W-1:0]                index;
  logic [`DC_WORD_W-1:0]                 fill_word;
  logic [`DC_WORD_W-1:0]                 wb_word;
  logic [31:0]                           wb_addr;
  logic [31:0]                           fill_addr;
  logic [31:0]                           rdata_word;
  logic [31:0]                           wb_data;
  logic [31:0]                           fill_data;
  logic                                  hit;
  logic                                  busy;
  logic                                  cpu_we;
  logic                                  wb_start;
  logic                                  fill_start;
  logic                                  fill_we;
  logic                                  burst_done;

  dcache_lookup u_lookup (
    .clk(clk), .rst(rst), .req(req), .cpu_req(cpu_req), .busy(busy),
    .entries(entries), .ages(ages), .held(held), .index(index),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
  );

  dcache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .req(req), .held(held), .hit(hit),
    .hit_way(hit_way), .victim_way(victim_way), .entries(entries), .ages(ages),
    .burst_done(burst_done), .rdata_word(rdata_word), .busy(busy), .ok(ok),
    .rdata(rdata), .cpu_we(cpu_we), .sel_way(sel_way), .tag_we(tag_we),
    .tag_wdata(tag_wdata), .age_we(age_we), .age_wdata(age_wdata),
    .wb_start(wb_start), .fill_start(fill_start), .wb_addr(wb_addr),
    .fill_addr(fill_addr)
  );

  dcache_mem_port u_mem_port (
    .clk(clk), .rst(rst), .wb_start(wb_start), .fill_start(fill_start),
    .wb_addr(wb_addr), .fill_addr(fill_addr), .sdata(sdata),
    .rdata_ok(rdata_ok), .wdata_ok(wdata_ok), .wb_data(wb_data),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .fill_we(fill_we), .fill_word(fill_word),
    .fill_data(fill_data), .wb_word(wb_word), .burst_done(burst_done)
  );

  dcache_data_array u_data (
    .clk(clk), .index(held.addr.index), .word(held.addr.word),
    .cpu_we(cpu_we), .cpu_way(sel_way), .wbyte(held.wbyte), .wdata(held.wdata),
    .fill_we(fill_we), .fill_word(fill_word), .fill_data(fill_data),
    .wb_word(wb_word), .rdata(rdata_word), .wb_data(wb_data)
  );

  // Tag entry and LRU age store per way
  for (genvar g = 0; g < `DC_WAYS; g++)
  begin : g_way
    dcache_sram #(.entry_t(dcache_pkg::tag_entry_t)) u_tag (
      .clk(clk), .rst(rst), .index(index), .we(tag_we[g]),
      .wdata(tag_wdata), .rdata(entries[g])
    );
    dcache_sram #(.entry_t(dcache_pkg::age_t)) u_age (
      .clk(clk), .rst(rst), .index(index), .we(age_we[g]),
      .wdata(age_wdata[g]), .rdata(ages[g])
    );
  end

endmodule

// File: include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Address split, tag | index | word | byte
`define DC_TAG_W      22
`define DC_INDEX_W    4
`define DC_WORD_W     4

// Organisation
`define DC_WAYS       4
`define DC_LINE_WORDS 16

// LRU age counter width
`define DC_AGE_W      2

`endif

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// File: test/dcache_tb.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_tb;

  localparam int          timeout_cycles = 2000;
  localparam logic [31:0] first_addr     = 32'h0000_414c;  // Set 5, tag 0x10, word 3
  localparam logic [31:0] first_line     = 32'h0000_4140;
  localparam logic [31:0] first_word     = 32'hcafe_0001;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  wbyte;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic        exp_hit;
  } step_t;

  logic                 clk;
  logic                 rst;
  logic                 req;
  dcache_pkg::cpu_req_t cpu_req;
  logic                 ok;
  logic [31:0]          rdata;
  dcache_pkg::mem_rd_t  mem_rd;
  dcache_pkg::mem_wr_t  mem_wr;
  logic [31:0]          sdata    = '0;
  logic                 rdata_ok = 1'b0;
  logic                 wdata_ok = 1'b0;

  step_t       steps[$];
  string       step_names[$];
  logic [31:0] mem_model [logic [31:0]];
  logic [31:0] wb_addr_q[$];
  logic [31:0] wb_data_q[$];
  logic [31:0] lfsr    = 32'h7a89;
  logic        rd_go   = 1'b0;
  logic        wr_go   = 1'b0;
  logic        wen_q   = 1'b0;
  logic        started = 1'b0;
  logic        timed_out = 1'b0;
  int          rd_idx  = 0;
  int          wr_idx  = 0;
  int          errors  = 0;
  int          checks  = 0;

  dcache_top dut0 (
    .clk(clk), .rst(rst), .req(req), .cpu_req(cpu_req), .ok(ok), .rdata(rdata),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .sdata(sdata), .rdata_ok(rdata_ok),
    .wdata_ok(wdata_ok)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  // Memory content never written
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return a ^ 32'h5a5a0000;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    if (mem_model.exists(a))
      return mem_model[a];
    return init_word(a);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("Fail %0s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic add_step(input string name, input logic [31:0] addr, input logic we,
                          input logic [3:0] wbyte, input logic [31:0] wdata,
                          input logic [31:0] exp_data, input logic exp_hit);
    step_t s;
    s.addr     = addr;
    s.we       = we;
    s.wbyte    = wbyte;
    s.wdata    = wdata;
    s.exp_data = exp_data;
    s.exp_hit  = exp_hit;
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  task automatic build_table();
    // Set 1, read miss then hits and a byte write
    add_step("rd_miss", 32'h1048, 1'b0, 4'h0, 32'h0, init_word(32'h1048), 1'b0);
    add_step("rd_hit", 32'h1048, 1'b0, 4'h0, 32'h0, init_word(32'h1048), 1'b1);
    add_step("rd_hit_w15", 32'h107c, 1'b0, 4'h0, 32'h0, init_word(32'h107c), 1'b1);
    add_step("wr_byte", 32'h1048, 1'b1, 4'b0101, 32'haabbccdd, 32'haabbccdd, 1'b1);
    add_step("rd_merged", 32'h1048, 1'b0, 4'h0, 32'h0,
             merge_bytes(init_word(32'h1048), 32'haabbccdd, 4'b0101), 1'b1);
    // Set 2, write allocate
    add_step("wr_miss", 32'h2484, 1'b1, 4'b1100, 32'h11223344, 32'h11223344, 1'b0);
    add_step("rd_alloc", 32'h2484, 1'b0, 4'h0, 32'h0,
             merge_bytes(init_word(32'h2484), 32'h11223344, 4'b1100), 1'b1);
    // Set 5, five tags, first one dirty
    add_step("wr_first", first_addr, 1'b1, 4'hf, first_word, first_word, 1'b0);
    add_step("rd_tag1", first_addr + 32'h400, 1'b0, 4'h0, 32'h0,
             init_word(first_addr + 32'h400), 1'b0);
    add_step("rd_tag2", first_addr + 32'h800, 1'b0, 4'h0, 32'h0,
             init_word(first_addr + 32'h800), 1'b0);
    add_step("rd_tag3", first_addr + 32'hc00, 1'b0, 4'h0, 32'h0,
             init_word(first_addr + 32'hc00), 1'b0);
    add_step("rd_tag4", first_addr + 32'h1000, 1'b0, 4'h0, 32'h0,
             init_word(first_addr + 32'h1000), 1'b0);  // Evicts the first line
    add_step("rd_evicted", first_addr, 1'b0, 4'h0, 32'h0, first_word, 1'b0);
  endtask

  task automatic issue_request(input int i);
    step_t s;
    string name;
    int    lat;
    s    = steps[i];
    name = step_names[i];
    lat  = 1;
    @(posedge clk);
    started = 1'b1;
    req           <= 1'b1;
    cpu_req.addr  <= s.addr;
    cpu_req.wdata <= s.wdata;
    cpu_req.wbyte <= s.wbyte;
    cpu_req.we    <= s.we;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (!ok && lat < timeout_cycles)
    begin
      lat++;
      @(negedge clk);
    end
    if (!ok)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout waiting for ok on request %0s", name);
    end
    else
    begin
      check_value(name, s.exp_data, rdata);
      if (s.exp_hit)
        check_value($sformatf("%0s_latency", name), 32'd2, lat);
      else
        check_value($sformatf("%0s_miss", name), 32'd1, (lat > 2) ? 32'd1 : 32'd0);
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rst)
    begin
      rdata_ok <= 1'b0;
      wdata_ok <= 1'b0;
      sdata    <= '0;
      rd_idx = 0;
      wr_idx = 0;
    end
    else
    begin
      if (mem_rd.sen && rdata_ok)
        rd_idx = rd_idx + 1;
      if (!mem_rd.sen)
        rd_idx = 0;
      rd_go = 1'b0;
      if (mem_rd.sen && rd_idx < 16)
      begin
        lfsr  = lfsr_step(lfsr);
        rd_go = lfsr[0];
      end
      rdata_ok <= rd_go;
      if (rd_go)
        sdata <= model_read(mem_rd.raddr + (rd_idx << 2));

      // Write side accepts the word on the bus
      if (mem_wr.wen && wdata_ok)
      begin
        mem_model[mem_wr.waddr + (wr_idx << 2)] = mem_wr.wdata;
        wr_idx = wr_idx + 1;
      end
      if (!mem_wr.wen)
        wr_idx = 0;
      wr_go = 1'b0;
      if (mem_wr.wen && wr_idx < 16)
      begin
        lfsr  = lfsr_step(lfsr);
        wr_go = lfsr[0];
      end
      wdata_ok <= wr_go;
    end
  end

  // Write-back burst monitor
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (mem_wr.wen && !wen_q)
        wb_addr_q.push_back(mem_wr.waddr);
      if (mem_wr.wen && wdata_ok)
        wb_data_q.push_back(mem_wr.wdata);
      wen_q <= mem_wr.wen;
    end
  end

  // Quiet outputs until the first request
  always @(negedge clk)
  begin
    if (!started)
    begin
      check_value("idle_ok", 32'd0, {31'd0, ok});
      check_value("idle_sen", 32'd0, {31'd0, mem_rd.sen});
      check_value("idle_wen", 32'd0, {31'd0, mem_wr.wen});
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    rst     = 1'b1;
    req     = 1'b0;
    cpu_req = '0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    for (int i = 0; i < steps.size() && !timed_out; i++)
      issue_request(i);

    // One write-back, of the dirty first line only
    check_value("wb_bursts", 32'd1, wb_addr_q.size());
    if (wb_addr_q.size() > 0)
      check_value("wb_addr", first_line, wb_addr_q[0]);
    check_value("wb_words", 32'd16, wb_data_q.size());
    if (wb_data_q.size() == 16)
    begin
      for (int w = 0; w < 16; w++)
        check_value($sformatf("wb_word%0d", w),
                    (w == 3) ? first_word : init_word(first_line + (w << 2)),
                    wb_data_q[w]);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule
